/* rtl/fp_fmt_pkg.sv */
// binary32 format definitions
package fp_fmt_pkg;

	localparam int EXP_W  = 8;	// exponent field
	localparam int FRAC_W = 23;	// stored fraction, hidden bit excluded
	localparam int WORD_W = 1 + EXP_W + FRAC_W;
	localparam int BIAS   = 127;

	// all-ones exponent marks inf and NaN
	localparam logic [EXP_W-1:0] EXP_MAX = '1;

	// operand or result word
	typedef logic [WORD_W-1:0] word_t;

	// exponent with one spare bit so carries past EXP_MAX stay visible
	typedef logic [EXP_W:0] exp_t;

	// canonical quiet NaN
	localparam word_t QNAN_WORD = {1'b0, EXP_MAX, 1'b1, {(FRAC_W-1){1'b0}}};

endpackage

/* rtl/fp_op_pkg.sv */
// rounding and exception definitions
package fp_op_pkg;

	typedef enum logic [2:0] {
		RNE = 3'd0,	// nearest with ties to even
		RTZ = 3'd1,	// toward zero
		RDN = 3'd2,	// toward -inf
		RUP = 3'd3,	// toward +inf
		RMM = 3'd4	// nearest with ties away from zero
	} rnd_mode_t;

	localparam int GUARD_W = 3;	// guard, round and sticky

	// carry bit + hidden bit + fraction + guard bits
	localparam int MANT_W = 1 + 1 + fp_fmt_pkg::FRAC_W + GUARD_W;

	// fflags order, nv in the top bit
	typedef struct packed {
		logic nv;	// invalid op
		logic dz;	// never set by add
		logic of;	// overflow
		logic uf;	// never set here
		logic nx;	// inexact
	} flags_t;

endpackage

/* rtl/fp_classify.sv */
// operand unpack and special detect
module fp_classify (
	input  logic                         sub,
	input  fp_fmt_pkg::word_t            in_1,
	input  fp_fmt_pkg::word_t            in_2,
	output logic                         sign_1,
	output logic                         sign_2,
	output fp_fmt_pkg::exp_t             exp_1,
	output fp_fmt_pkg::exp_t             exp_2,
	output logic [fp_op_pkg::MANT_W-2:0] mant_1,
	output logic [fp_op_pkg::MANT_W-2:0] mant_2,
	output logic                         is_nan,
	output logic                         nan_quiet,
	output logic                         is_inf,
	output logic                         inf_sign,
	output logic                         zero_same_sign
);
	import fp_fmt_pkg::*;
	import fp_op_pkg::*;

	word_t             in_w [2];
	logic [EXP_W-1:0]  e [2];
	logic [FRAC_W-1:0] f [2];
	logic [1:0]        nan_w;
	logic [1:0]        snan_w;
	logic [1:0]        inf_w;
	logic [1:0]        zero_w;
	logic              bad_inf;

	assign in_w[0] = in_1;
	assign in_w[1] = in_2;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			e[i]      = in_w[i][WORD_W-2 -: EXP_W];
			f[i]      = in_w[i][FRAC_W-1:0];
			nan_w[i]  = (e[i] == EXP_MAX) && (f[i] != '0);
			snan_w[i] = nan_w[i] && !f[i][FRAC_W-1];	// quiet bit clear
			inf_w[i]  = (e[i] == EXP_MAX) && (f[i] == '0);
			zero_w[i] = (e[i] == '0) && (f[i] == '0);
		end
	end

	assign sign_1 = in_1[WORD_W-1];
	assign sign_2 = in_2[WORD_W-1] ^ (sub & ~nan_w[1]);	// a NaN keeps its sign

	// subnormals sit at the same scale as exponent 1
	assign exp_1  = (e[0] == '0) ? exp_t'(1) : exp_t'(e[0]);
	assign exp_2  = (e[1] == '0) ? exp_t'(1) : exp_t'(e[1]);
	assign mant_1 = {e[0] != '0, f[0], {GUARD_W{1'b0}}};
	assign mant_2 = {e[1] != '0, f[1], {GUARD_W{1'b0}}};

	// inf - inf has no answer
	assign bad_inf = inf_w[0] && inf_w[1] && (sign_1 != sign_2);

	assign is_nan         = (|nan_w) || bad_inf;
	assign nan_quiet      = !((|snan_w) || bad_inf);
	assign is_inf         = |inf_w;
	assign inf_sign       = (inf_w[0] & sign_1) | (inf_w[1] & sign_2);
	assign zero_same_sign = (&zero_w) && (sign_1 == sign_2);

endmodule

/* rtl/fp_align_add.sv */
// alignment, mantissa add and stage register
module fp_align_add #(
	parameter int TAG_W = 6
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  fp_op_pkg::rnd_mode_t         rnd,
	input  logic [TAG_W-1:0]             tag,
	input  logic                         sign_1,
	input  logic                         sign_2,
	input  fp_fmt_pkg::exp_t             exp_1,
	input  fp_fmt_pkg::exp_t             exp_2,
	input  logic [fp_op_pkg::MANT_W-2:0] mant_1,
	input  logic [fp_op_pkg::MANT_W-2:0] mant_2,
	input  logic                         is_nan,
	input  logic                         nan_quiet,
	input  logic                         is_inf,
	input  logic                         inf_sign,
	input  logic                         zero_same_sign,
	output logic                         valid,
	output logic [fp_op_pkg::MANT_W:0]   r_sum,
	output logic                         r_sign,
	output fp_fmt_pkg::exp_t             r_exp,
	output fp_op_pkg::rnd_mode_t         r_rnd,
	output logic [TAG_W-1:0]             r_tag,
	output logic                         r_is_nan,
	output logic                         r_nan_quiet,
	output logic                         r_is_inf,
	output logic                         r_inf_sign,
	output logic                         r_zero_same_sign
);
	import fp_fmt_pkg::*;
	import fp_op_pkg::*;

	localparam int M   = MANT_W - 1;	// aligned mantissa width
	localparam int SHW = $clog2(M + 1);

	logic              exp_ge;
	exp_t              exp_big;
	exp_t              exp_diff;
	logic [M-1:0]      m_small;
	logic [SHW-1:0]    sh;
	logic [2*M-1:0]    wide;
	logic [M-1:0]      m_shifted;
	logic [M-1:0]      am_1;
	logic [M-1:0]      am_2;
	logic [MANT_W-1:0] op_1;
	logic [MANT_W-1:0] op_2;
	logic              cin;
	logic              sign_x;
	logic [MANT_W:0]   sum;

	assign exp_ge   = exp_1 >= exp_2;
	assign exp_big  = exp_ge ? exp_1 : exp_2;
	assign exp_diff = exp_ge ? (exp_1 - exp_2) : (exp_2 - exp_1);
	assign m_small  = exp_ge ? mant_2 : mant_1;

	// anything shifted past the guard bits only survives as sticky
	assign sh        = (exp_diff > exp_t'(M)) ? SHW'(M) : exp_diff[SHW-1:0];
	assign wide      = {m_small, {M{1'b0}}} >> sh;
	assign m_shifted = wide[2*M-1:M] | {{(M-1){1'b0}}, |wide[M-1:0]};

	assign am_1 = exp_ge ? mant_1 : m_shifted;
	assign am_2 = exp_ge ? m_shifted : mant_2;

	// ones complement plus carry in on the negative side
	always_comb begin
		op_1   = {1'b0, am_1};
		op_2   = {1'b0, am_2};
		sign_x = 1'b0;
		cin    = 1'b0;
		if (sign_1 && sign_2) begin
			sign_x = 1'b1;	// both negative so add magnitudes
		end else if (sign_1) begin
			op_1 = ~op_1;	// m2 - m1
			cin  = 1'b1;
		end else if (sign_2) begin
			op_2 = ~op_2;	// m1 - m2
			cin  = 1'b1;
		end
	end

	assign sum = {op_1[MANT_W-1], op_1} + {op_2[MANT_W-1], op_2} + (MANT_W+1)'(cin);

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
		end else begin
			valid <= start;
		end
	end

	always_ff @(posedge clk) begin
		r_sum            <= sum;
		r_sign           <= sign_x;
		r_exp            <= exp_big;
		r_rnd            <= rnd;
		r_tag            <= tag;
		r_is_nan         <= is_nan;
		r_nan_quiet      <= nan_quiet;
		r_is_inf         <= is_inf;
		r_inf_sign       <= inf_sign;
		r_zero_same_sign <= zero_same_sign;
	end

	// a started op must bring known operands and control
	inputs_known_on_start: assert property (@(posedge clk) disable iff (reset)
		start |-> !$isunknown({rnd, tag, sign_1, sign_2, exp_1, exp_2, mant_1, mant_2}))
		else $error("start with unknown operand or control bits");

endmodule

/* rtl/fp_normalize.sv */
// sum magnitude and normalization
module fp_normalize (
	input  logic [fp_op_pkg::MANT_W:0]   r_sum,
	input  logic                         r_sign,
	input  fp_fmt_pkg::exp_t             r_exp,
	output logic [fp_op_pkg::MANT_W-2:0] mant_norm,
	output fp_fmt_pkg::exp_t             exp_norm,
	output logic                         sign_out,
	output logic                         exp_overflow,
	output logic                         is_zero
);
	import fp_fmt_pkg::*;
	import fp_op_pkg::*;

	localparam int M = MANT_W - 1;

	logic [MANT_W-1:0] mag;
	logic [4:0]        lz;
	exp_t              shl;

	// back to a magnitude, flipping the sign for a negative sum
	assign mag      = r_sum[MANT_W] ? (~r_sum[MANT_W-1:0] + 1'b1) : r_sum[MANT_W-1:0];
	assign sign_out = r_sign ^ r_sum[MANT_W];
	assign is_zero  = (mag == '0);

	// leading zeros below the carry bit
	always_comb begin
		lz = 5'(M);
		for (int i = 0; i < M; i++) begin
			if (mag[i]) begin
				lz = 5'(M - 1 - i);
			end
		end
	end

	always_comb begin
		shl          = '0;
		exp_overflow = 1'b0;
		if (mag[MANT_W-1]) begin
			// carry out, one step right keeping sticky
			mant_norm    = {mag[MANT_W-1:2], mag[1] | mag[0]};
			exp_norm     = r_exp + 1'b1;
			exp_overflow = r_exp >= exp_t'(EXP_MAX - 1'b1);
		end else if (is_zero) begin
			mant_norm = '0;
			exp_norm  = '0;
		end else begin
			if (exp_t'(lz) < r_exp) begin
				shl      = exp_t'(lz);
				exp_norm = r_exp - exp_t'(lz);
			end else begin
				shl      = r_exp - 1'b1;	// stop at subnormal scale
				exp_norm = '0;
			end
			mant_norm = mag[M-1:0] << shl;
		end
	end

	// a normal exponent always comes with the hidden bit
	hidden_bit_set: assert final ($isunknown(exp_norm) || exp_norm == '0 || mant_norm[M-1])
		else $error("normalized mantissa lacks its hidden bit");

endmodule

/* rtl/fp_round_pack.sv */
// rounding, specials and result packing
module fp_round_pack (
	input  logic [fp_op_pkg::MANT_W-2:0] mant_norm,
	input  fp_fmt_pkg::exp_t             exp_norm,
	input  logic                         sign_out,
	input  logic                         exp_overflow,
	input  logic                         is_zero,
	input  fp_op_pkg::rnd_mode_t         r_rnd,
	input  logic                         r_is_nan,
	input  logic                         r_nan_quiet,
	input  logic                         r_is_inf,
	input  logic                         r_inf_sign,
	input  logic                         r_zero_same_sign,
	output fp_fmt_pkg::word_t            res,
	output fp_op_pkg::flags_t            exceptions
);
	import fp_fmt_pkg::*;
	import fp_op_pkg::*;

	localparam int M = MANT_W - 1;
	localparam logic [GUARD_W-1:0] HALF = 1 << (GUARD_W - 1);	// exactly half an ulp

	logic [GUARD_W-1:0] grs;
	logic               lsb;
	logic               inc;
	logic               trunc_ovf;	// mode clamps overflow to max finite
	logic [FRAC_W+1:0]  rounded;	// carry, hidden, fraction
	exp_t               exp_r;
	logic [FRAC_W-1:0]  frac_r;
	logic               ovf;
	logic               res_sign;

	assign grs = mant_norm[GUARD_W-1:0];
	assign lsb = mant_norm[GUARD_W];

	always_comb begin
		inc       = 1'b0;
		trunc_ovf = 1'b0;
		case (r_rnd)
			RNE: inc = (grs > HALF) || (grs == HALF && lsb);
			RTZ: trunc_ovf = 1'b1;
			RDN: begin
				inc       = (grs != '0) && sign_out;
				trunc_ovf = !sign_out;
			end
			RUP: begin
				inc       = (grs != '0) && !sign_out;
				trunc_ovf = sign_out;
			end
			RMM: inc = grs >= HALF;
			default: inc = 1'b0;
		endcase
	end

	assign rounded = {1'b0, mant_norm[M-1:GUARD_W]} + (FRAC_W+2)'(inc);

	always_comb begin
		frac_r = rounded[FRAC_W-1:0];
		exp_r  = exp_norm;
		if (rounded[FRAC_W+1]) begin
			frac_r = rounded[FRAC_W:1];	// wrapped to 2.0
			exp_r  = exp_norm + 1'b1;
		end else if (exp_norm == '0 && rounded[FRAC_W]) begin
			exp_r = exp_t'(1);	// subnormal rounded up to the smallest normal
		end
	end

	assign ovf = exp_overflow || (exp_r >= exp_t'(EXP_MAX));

	// exact zero is +0 unless both inputs were zeros of one sign, or RDN
	assign res_sign = (is_zero && !r_zero_same_sign) ? (r_rnd == RDN) : sign_out;

	always_comb begin
		exceptions = '0;
		if (r_is_nan) begin
			res           = QNAN_WORD;
			exceptions.nv = !r_nan_quiet;
		end else if (!r_is_inf && ovf && trunc_ovf) begin
			res           = {sign_out, EXP_MAX - 1'b1, {FRAC_W{1'b1}}};	// largest finite
			exceptions.of = 1'b1;
		end else if (r_is_inf || ovf) begin
			res           = {r_is_inf ? r_inf_sign : sign_out, EXP_MAX, {FRAC_W{1'b0}}};
			exceptions.of = !r_is_inf;
		end else begin
			res = {res_sign, exp_r[EXP_W-1:0], frac_r};
		end
		exceptions.nx = (ovf || grs != '0) && !r_is_inf && !r_is_nan;
	end

endmodule

/* rtl/fp_add_sub.sv */
// binary32 add and subtract
module fp_add_sub #(
	parameter int TAG_W = 6
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  logic                 sub,
	input  fp_op_pkg::rnd_mode_t rnd,
	input  fp_fmt_pkg::word_t    in_1,
	input  fp_fmt_pkg::word_t    in_2,
	input  logic [TAG_W-1:0]     tag,
	output logic                 valid,
	output fp_fmt_pkg::word_t    res,
	output fp_op_pkg::flags_t    exceptions,
	output logic [TAG_W-1:0]     tag_out
);
	import fp_fmt_pkg::*;
	import fp_op_pkg::*;

	// before the stage register
	logic              sign_1;
	logic              sign_2;
	exp_t              exp_1;
	exp_t              exp_2;
	logic [MANT_W-2:0] mant_1;
	logic [MANT_W-2:0] mant_2;
	logic              is_nan;
	logic              nan_quiet;
	logic              is_inf;
	logic              inf_sign;
	logic              zero_same_sign;

	// after the stage register
	logic [MANT_W:0]   r_sum;
	logic              r_sign;
	exp_t              r_exp;
	rnd_mode_t         r_rnd;
	logic              r_is_nan;
	logic              r_nan_quiet;
	logic              r_is_inf;
	logic              r_inf_sign;
	logic              r_zero_same_sign;
	logic [MANT_W-2:0] mant_norm;
	exp_t              exp_norm;
	logic              sign_out;
	logic              exp_overflow;
	logic              is_zero;

	fp_classify u_classify (
		.sub            (sub),
		.in_1           (in_1),
		.in_2           (in_2),
		.sign_1         (sign_1),
		.sign_2         (sign_2),
		.exp_1          (exp_1),
		.exp_2          (exp_2),
		.mant_1         (mant_1),
		.mant_2         (mant_2),
		.is_nan         (is_nan),
		.nan_quiet      (nan_quiet),
		.is_inf         (is_inf),
		.inf_sign       (inf_sign),
		.zero_same_sign (zero_same_sign)
	);

	fp_align_add #(
		.TAG_W (TAG_W)
	) u_align_add (
		.clk              (clk),
		.reset            (reset),
		.start            (start),
		.rnd              (rnd),
		.tag              (tag),
		.sign_1           (sign_1),
		.sign_2           (sign_2),
		.exp_1            (exp_1),
		.exp_2            (exp_2),
		.mant_1           (mant_1),
		.mant_2           (mant_2),
		.is_nan           (is_nan),
		.nan_quiet        (nan_quiet),
		.is_inf           (is_inf),
		.inf_sign         (inf_sign),
		.zero_same_sign   (zero_same_sign),
		.valid            (valid),
		.r_sum            (r_sum),
		.r_sign           (r_sign),
		.r_exp            (r_exp),
		.r_rnd            (r_rnd),
		.r_tag            (tag_out),
		.r_is_nan         (r_is_nan),
		.r_nan_quiet      (r_nan_quiet),
		.r_is_inf         (r_is_inf),
		.r_inf_sign       (r_inf_sign),
		.r_zero_same_sign (r_zero_same_sign)
	);

	fp_normalize u_normalize (
		.r_sum        (r_sum),
		.r_sign       (r_sign),
		.r_exp        (r_exp),
		.mant_norm    (mant_norm),
		.exp_norm     (exp_norm),
		.sign_out     (sign_out),
		.exp_overflow (exp_overflow),
		.is_zero      (is_zero)
	);

	fp_round_pack u_round_pack (
		.mant_norm        (mant_norm),
		.exp_norm         (exp_norm),
		.sign_out         (sign_out),
		.exp_overflow     (exp_overflow),
		.is_zero          (is_zero),
		.r_rnd            (r_rnd),
		.r_is_nan         (r_is_nan),
		.r_nan_quiet      (r_nan_quiet),
		.r_is_inf         (r_is_inf),
		.r_inf_sign       (r_inf_sign),
		.r_zero_same_sign (r_zero_same_sign),
		.res              (res),
		.exceptions       (exceptions)
	);

endmodule

/* verif/fp_ref_model.svh */
// binary32 add reference model
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

localparam int REF_W = 320;	// room for the widest alignment

// exact sum of a and b, then rounded by mode into flags and result word
function automatic logic [36:0] ref_fp_add(input word_t a, input word_t b, input logic do_sub,
		input rnd_mode_t mode);
	logic              sa, sb, sign_r, inc, to_inf, snan;
	logic [EXP_W-1:0]  ea, eb;
	logic [FRAC_W-1:0] fa, fb;
	int                sca, scb, emin, p, e_res, s;
	logic [REF_W-1:0]  ma, mb, mag, q, rem, half;
	flags_t            fl;
	word_t             r;

	sa = a[WORD_W-1];
	sb = b[WORD_W-1] ^ do_sub;
	ea = a[WORD_W-2 -: EXP_W];
	eb = b[WORD_W-2 -: EXP_W];
	fa = a[FRAC_W-1:0];
	fb = b[FRAC_W-1:0];
	fl = '0;
	snan = (ea == EXP_MAX && fa != 0 && !fa[FRAC_W-1]) || (eb == EXP_MAX && fb != 0 && !fb[FRAC_W-1]);
	if ((ea == EXP_MAX && fa != 0) || (eb == EXP_MAX && fb != 0)) begin
		fl.nv = snan;	// only a signalling NaN is invalid
		return {fl, QNAN_WORD};
	end
	if (ea == EXP_MAX && eb == EXP_MAX && sa != sb) begin
		fl.nv = 1'b1;	// opposite infinities
		return {fl, QNAN_WORD};
	end
	if (ea == EXP_MAX) begin
		return {fl, {sa, EXP_MAX, {FRAC_W{1'b0}}}};
	end
	if (eb == EXP_MAX) begin
		return {fl, {sb, EXP_MAX, {FRAC_W{1'b0}}}};
	end

	// integer significands on the scale of the smaller exponent
	sca  = (ea == 0) ? 1 : int'(ea);
	scb  = (eb == 0) ? 1 : int'(eb);
	emin = (sca < scb) ? sca : scb;
	ma   = REF_W'({ea != 0, fa}) << (sca - emin);
	mb   = REF_W'({eb != 0, fb}) << (scb - emin);
	if (sa == sb || ma >= mb) begin
		mag    = (sa == sb) ? ma + mb : ma - mb;
		sign_r = sa;
	end else begin
		mag    = mb - ma;
		sign_r = sb;
	end
	if (mag == 0) begin
		sign_r = (sa == sb) ? sa : (mode == RDN);	// exact zero
		return {fl, {sign_r, {(WORD_W-1){1'b0}}}};
	end

	p = 0;
	for (int i = 0; i < REF_W; i++) begin
		if (mag[i]) begin
			p = i;
		end
	end
	e_res = p - FRAC_W + emin;
	if (e_res < 1) begin
		e_res = 1;	// subnormal scale floor
	end
	s = e_res - emin;
	if (s <= 0) begin
		q    = mag << (-s);
		rem  = '0;
		half = '0;
	end else begin
		q    = mag >> s;
		rem  = mag & ((REF_W'(1) << s) - 1);
		half = REF_W'(1) << (s - 1);
	end

	case (mode)
		RNE: inc = (rem > half) || (rem == half && q[0]);
		RDN: inc = sign_r;
		RUP: inc = !sign_r;
		RMM: inc = (rem >= half);
		default: inc = 1'b0;
	endcase
	inc = inc && (rem != 0);
	q   = q + inc;
	if (q[FRAC_W+1]) begin
		q = q >> 1;	// carried into the next binade
		e_res++;
	end

	fl.nx = (rem != 0);
	if (e_res >= int'(EXP_MAX)) begin
		fl.of  = 1'b1;
		fl.nx  = 1'b1;
		to_inf = (mode == RNE) || (mode == RMM) || (mode == RDN && sign_r) ||
			(mode == RUP && !sign_r);
		r = to_inf ? {sign_r, EXP_MAX, {FRAC_W{1'b0}}} : {sign_r, EXP_MAX - 1'b1, {FRAC_W{1'b1}}};
	end else begin
		r = {sign_r, q[FRAC_W] ? EXP_W'(e_res) : {EXP_W{1'b0}}, q[FRAC_W-1:0]};
	end
	return {fl, r};
endfunction

`endif

/* verif/fp_add_sub_tb.sv */
// fp adder testbench
module fp_add_sub_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fp_fmt_pkg::*;
	import fp_op_pkg::*;

	localparam int TAG_W        = 6;
	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYC    = 10;
	localparam int N_TESTS      = 6;
	localparam int RNE_OPS      = 300;
	localparam int MODE_OPS     = 600;
	localparam int TIME_OPS     = 60;
	localparam int TOTAL_OPS    = RNE_OPS + MODE_OPS + 98 + 20 + 25 + TIME_OPS;
	// idle gaps of the timing test and a short drain after each test
	localparam int WATCHDOG_CYC = RESET_CYC + TOTAL_OPS + TIME_OPS + N_TESTS * 4 + 20;

	typedef struct packed {
		logic [2:0]       test;
		word_t            a;
		word_t            b;
		logic             sub;
		rnd_mode_t        rnd;
		logic [TAG_W-1:0] tag;
		flags_t           flags;
		word_t            res;
	} op_rec_t;

	logic             clk;
	logic             reset;
	logic             start;
	logic             sub;
	rnd_mode_t        rnd;
	word_t            in_1;
	word_t            in_2;
	logic [TAG_W-1:0] tag;
	logic             valid;
	word_t            res;
	flags_t           exceptions;
	logic [TAG_W-1:0] tag_out;

	op_rec_t pending [$];	// ops in flight, oldest first
	int      cur_test    = 0;
	int      op_count    = 0;
	int      error_count = 0;
	int      test_errors [N_TESTS] = '{default: 0};
	int      test_ops [N_TESTS]    = '{default: 0};
	string   test_name [N_TESTS]   = '{"rne random", "modes random", "specials", "overflow",
		"zero sign", "timing"};

	`include "fp_ref_model.svh"

	fp_add_sub #(
		.TAG_W (TAG_W)
	) u_fp_add_sub (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.sub        (sub),
		.rnd        (rnd),
		.in_1       (in_1),
		.in_2       (in_2),
		.tag        (tag),
		.valid      (valid),
		.res        (res),
		.exceptions (exceptions),
		.tag_out    (tag_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic count_error(input int test_idx);
		error_count++;
		if (test_idx < N_TESTS) begin
			test_errors[test_idx]++;
		end
	endtask

	function automatic word_t rand_normal(input int lo, input int hi);
		return {1'($urandom), EXP_W'($urandom_range(hi, lo)), FRAC_W'($urandom)};
	endfunction

	// random operand with exponent within spread of a's
	function automatic word_t near_of(input word_t a, input int spread);
		int ea;
		ea = int'(a[WORD_W-2 -: EXP_W]);
		return rand_normal((ea > spread) ? ea - spread : 1,
			(ea + spread < 254) ? ea + spread : 254);
	endfunction

	// drive one op on the next rising edge and queue what it should give
	task automatic issue_op(input word_t a, input word_t b, input logic s, input rnd_mode_t m);
		op_rec_t rec;
		rec.test = 3'(cur_test);
		rec.a    = a;
		rec.b    = b;
		rec.sub  = s;
		rec.rnd  = m;
		rec.tag  = TAG_W'($urandom);
		{rec.flags, rec.res} = ref_fp_add(a, b, s, m);
		@(posedge clk);
		start <= 1'b1;
		sub   <= s;
		rnd   <= m;
		in_1  <= a;
		in_2  <= b;
		tag   <= rec.tag;
		pending.push_back(rec);
		op_count++;
		test_ops[cur_test]++;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic finish_test();
		idle_cycle();
		while (pending.size() != 0) begin
			@(negedge clk);
		end
		$display("test %0d %s: %0d ops, %0d errors", cur_test, test_name[cur_test],
			test_ops[cur_test], test_errors[cur_test]);
		cur_test++;
	endtask

	// stimulus
	initial begin
		word_t a;
		word_t b;
		word_t spec [7];
		int    kind;
		void'($urandom(32'h2025));
		spec  = '{32'h7fc00000, 32'h7f800001, 32'hffc12345, 32'h7f800000, 32'hff800000,
			32'h3f800000, 32'hf149f2ca};	// qnan, snan, -qnan, inf, -inf, 1.0, -1e30
		reset = 1'b1;
		start = 1'b0;
		sub   = 1'b0;
		rnd   = RNE;
		in_1  = '0;
		in_2  = '0;
		tag   = '0;
		repeat (RESET_CYC) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < RNE_OPS; i++) begin
			a = rand_normal(20, 230);
			issue_op(a, near_of(a, 30), 1'($urandom), RNE);
		end
		finish_test();

		// close exponents, near ties, subnormals and wide gaps
		for (int i = 0; i < MODE_OPS; i++) begin
			kind = $urandom_range(3, 0);
			a    = rand_normal(30, 220);
			case (kind)
				0: b = near_of(a, 8);
				1: b = {1'($urandom), a[WORD_W-2 -: EXP_W] - EXP_W'($urandom_range(26, 22)),
					{FRAC_W{1'b0}}};	// around half an ulp of a
				2: begin
					a = {1'($urandom), {EXP_W{1'b0}}, FRAC_W'($urandom)};
					b = {1'($urandom), EXP_W'($urandom_range(2, 0)), FRAC_W'($urandom)};
				end
				default: b = rand_normal(1, 254);
			endcase
			issue_op(a, b, 1'($urandom), rnd_mode_t'(i % 4 + 1));
		end
		finish_test();

		for (int i = 0; i < 7; i++) begin
			for (int j = 0; j < 7; j++) begin
				issue_op(spec[i], spec[j], 1'b0, rnd_mode_t'($urandom_range(4, 0)));
				issue_op(spec[i], spec[j], 1'b1, rnd_mode_t'($urandom_range(4, 0)));
			end
		end
		finish_test();

		// max finite doubled, and max finite plus half an ulp
		for (int m = 0; m < 5; m++) begin
			for (int s = 0; s < 2; s++) begin
				a = {1'(s), 31'h7f7fffff};
				issue_op(a, a, 1'b0, rnd_mode_t'(m));
				issue_op(a, {1'(s), 31'h73000000}, 1'b0, rnd_mode_t'(m));
			end
		end
		finish_test();

		for (int m = 0; m < 5; m++) begin
			a = rand_normal(1, 254);
			issue_op(a, a, 1'b1, rnd_mode_t'(m));
			issue_op(a, a ^ 32'h80000000, 1'b0, rnd_mode_t'(m));
			issue_op(32'h80000000, 32'h80000000, 1'b0, rnd_mode_t'(m));
			issue_op(32'h0, 32'h0, 1'b1, rnd_mode_t'(m));
			issue_op(32'h80000000, 32'h0, 1'b1, rnd_mode_t'(m));
		end
		finish_test();

		for (int i = 0; i < TIME_OPS; i++) begin
			a = rand_normal(1, 254);
			issue_op(a, near_of(a, 4), 1'($urandom), rnd_mode_t'($urandom_range(4, 0)));
			if ($urandom_range(2, 0) == 0) begin
				idle_cycle();
			end
		end
		finish_test();

		$display("%0d tests, %0d ops, %0d errors", N_TESTS, op_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// scoreboard, sampled mid-cycle
	initial begin
		op_rec_t rec;
		logic    start_seen;	// start as the DUT took it on the last edge
		start_seen = 1'b0;
		forever begin
			@(negedge clk);
			if (reset) begin
				start_seen = 1'b0;
			end else begin
				assert (valid === start_seen) else begin
					$display("** Error at %0t: valid is %b, start one cycle earlier was %b",
						$time, valid, start_seen);
					count_error(cur_test);
				end
				if (valid === 1'b1 && pending.size() == 0) begin
					$display("valid went high at %0t with no operation outstanding", $time);
					count_error(cur_test);
				end else if (valid === 1'b1) begin
					rec = pending.pop_front();
					assert (res === rec.res) else begin
						$display("** Error at %0t: %h %s %h rnd %0d gave %h, expected %h", $time,
							rec.a, rec.sub ? "-" : "+", rec.b, rec.rnd, res, rec.res);
						count_error(rec.test);
					end
					assert (exceptions === rec.flags) else begin
						$display("** Error at %0t: %h %s %h rnd %0d flags %b, expected %b", $time,
							rec.a, rec.sub ? "-" : "+", rec.b, rec.rnd, exceptions, rec.flags);
						count_error(rec.test);
					end
					assert (tag_out === rec.tag) else begin
						$display("** Error at %0t: tag_out %0d, expected %0d", $time, tag_out,
							rec.tag);
						count_error(rec.test);
					end
				end
				start_seen = start;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("timeout: results still missing after %0d cycles", WATCHDOG_CYC);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* flist.f */
+incdir+verif
rtl/fp_fmt_pkg.sv
rtl/fp_op_pkg.sv
rtl/fp_classify.sv
rtl/fp_align_add.sv
rtl/fp_normalize.sv
rtl/fp_round_pack.sv
rtl/fp_add_sub.sv
verif/fp_add_sub_tb.sv
